//--- hw/tlb_defines.svh
`ifndef TLB_DEFINES_SVH
`define TLB_DEFINES_SVH

// tlb geometry
`define TLB_ENTRIES 4
`define TLB_IDX_W 2

// address layout
`define VA_W 32
`define PAGE_OFS_W 12

// entry field widths
`define VPN2_W 19
`define PFN_W 20
`define ASID_W 8

// va[31:30] for kseg0 and kseg1
`define SEG_UNMAPPED_TOP 2

// va[31:29] for kseg1, the uncached window
`define SEG_KSEG1 5

`endif

//--- hw/tlb_pkg.sv
`include "tlb_defines.svh"

package tlb_pkg;

	// data port access opcode
	typedef enum logic {
		acc_load  = 1'b0,
		acc_store = 1'b1
	} access_kind_e;

	// one tlb entry, even page pair in pfn0, odd page in pfn1
	typedef struct packed {
		logic [`VPN2_W-1:0] vpn2;
		logic [`ASID_W-1:0] asid;
		logic               g;
		logic [`PFN_W-1:0]  pfn0;
		logic               d0;
		logic               v0;
		logic [`PFN_W-1:0]  pfn1;
		logic               d1;
		logic               v1;
	} tlb_entry_t;

	// lookup request from the data port
	typedef struct packed {
		logic [`VA_W-1:0]   va;
		logic [`ASID_W-1:0] asid;
		access_kind_e       kind;
	} lookup_req_t;

	// request after segment classification
	// va already holds the physical address when unmapped
	typedef struct packed {
		logic               valid;
		logic [`VA_W-1:0]   va;
		logic [`ASID_W-1:0] asid;
		access_kind_e       kind;
		logic               mapped;
		logic               uncache;
	} seg_stage_t;

	// per entry compare result, page already picked by va[12]
	typedef struct packed {
		logic              hit;
		logic [`PFN_W-1:0] pfn;
		logic              v;
		logic              d;
	} entry_match_t;

	// translated result with fault flags
	typedef struct packed {
		logic [`VA_W-1:0]      pa;
		logic                  miss;
		logic                  invalid;
		logic                  modify;
		logic                  uncache;
		logic                  mapped;
		logic [`TLB_IDX_W-1:0] index;
	} tlb_result_t;

endpackage

//--- hw/addr_segment_map.sv
`timescale 1ns/1ps
`include "tlb_defines.svh"

module addr_segment_map
	import tlb_pkg::*;
(
	input  logic        aclk,
	input  logic        rst,
	input  logic        lookup_valid,
	input  lookup_req_t req,
	output seg_stage_t  stage
);

	logic             unmapped;
	logic             uncache;
	logic [`VA_W-1:0] va_xlat;

	// kseg0 and kseg1 share the top two bits
	assign unmapped = (req.va[`VA_W-1 -: 2] == 2'(`SEG_UNMAPPED_TOP));

	// kseg1 bypasses the cache
	assign uncache = (req.va[`VA_W-1 -: 3] == 3'(`SEG_KSEG1));

	// unmapped windows drop the top three bits
	always_comb begin
		if (unmapped) begin
			va_xlat = {3'b000, req.va[`VA_W-4:0]};
		end else begin
			va_xlat = req.va;
		end
	end

	always_ff @(posedge aclk) begin
		if (!rst) begin
			stage.valid <= 1'b0;
		end else begin
			stage.valid <= lookup_valid;
		end
		// payload only moves with a request
		if (lookup_valid) begin
			stage.va      <= va_xlat;
			stage.asid    <= req.asid;
			stage.kind    <= req.kind;
			stage.mapped  <= ~unmapped;
			stage.uncache <= uncache;
		end
	end

endmodule

//--- hw/tlb_entry.sv
`timescale 1ns/1ps
`include "tlb_defines.svh"

module tlb_entry
	import tlb_pkg::*;
#(
	parameter int ENTRY_ID = 0
) (
	input  logic                  aclk,
	input  logic                  rst,
	input  logic                  tlb_we,
	input  logic [`TLB_IDX_W-1:0] wr_index,
	input  tlb_entry_t            wr_entry,
	input  seg_stage_t            stage,
	output entry_match_t          match
);

	tlb_entry_t         ent;
	logic               wr_sel;
	logic [`VPN2_W-1:0] va_vpn2;
	logic               vpn_eq;
	logic               asid_eq;
	logic               odd_page;

	// tlbwi style write by index
	assign wr_sel = tlb_we && (wr_index == `TLB_IDX_W'(ENTRY_ID));

	always_ff @(posedge aclk) begin
		if (!rst) begin
			ent <= '0;
		end else if (wr_sel) begin
			ent <= wr_entry;
		end
	end

	assign va_vpn2  = stage.va[`VA_W-1 -: `VPN2_W];
	assign odd_page = stage.va[`PAGE_OFS_W];

	assign vpn_eq  = (ent.vpn2 == va_vpn2);
	assign asid_eq = (ent.asid == stage.asid);

	// global entries ignore the asid
	assign match.hit = stage.valid && stage.mapped && vpn_eq && (ent.g || asid_eq);

	// even or odd half of the page pair
	always_comb begin
		if (odd_page) begin
			match.pfn = ent.pfn1;
			match.v   = ent.v1;
			match.d   = ent.d1;
		end else begin
			match.pfn = ent.pfn0;
			match.v   = ent.v0;
			match.d   = ent.d0;
		end
	end

endmodule

//--- hw/tlb_hit_resolve.sv
`timescale 1ns/1ps
`include "tlb_defines.svh"

module tlb_hit_resolve
	import tlb_pkg::*;
(
	input  logic         aclk,
	input  logic         rst,
	input  seg_stage_t   stage,
	input  entry_match_t match [`TLB_ENTRIES],
	output logic         result_valid,
	output tlb_result_t  result
);

	logic                  any_hit;
	logic [`TLB_IDX_W-1:0] hit_idx;
	entry_match_t          sel;
	logic                  is_store;
	tlb_result_t           res_nxt;

	// priority pick, scanning down so the lowest index wins
	always_comb begin
		any_hit = 1'b0;
		hit_idx = '0;
		sel     = '0;
		for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
			if (match[i].hit) begin
				any_hit = 1'b1;
				hit_idx = `TLB_IDX_W'(i);
				sel     = match[i];
			end
		end
	end

	assign is_store = (stage.kind == acc_store);

	always_comb begin
		res_nxt         = '0;
		res_nxt.mapped  = stage.mapped;
		res_nxt.uncache = stage.uncache;
		if (!stage.mapped) begin
			// already translated in the segment stage
			res_nxt.pa = stage.va;
		end else if (!any_hit) begin
			res_nxt.miss = 1'b1;
		end else if (!sel.v) begin
			res_nxt.invalid = 1'b1;
		end else begin
			res_nxt.pa     = {sel.pfn, stage.va[`PAGE_OFS_W-1:0]};
			res_nxt.index  = hit_idx;
			// store to a clean page
			res_nxt.modify = is_store && !sel.d;
		end
	end

	always_ff @(posedge aclk) begin
		if (!rst) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= stage.valid;
		end
		if (stage.valid) begin
			result <= res_nxt;
		end
	end

endmodule

//--- hw/tlb_mmu.sv
`timescale 1ns/1ps
`include "tlb_defines.svh"

module tlb_mmu
	import tlb_pkg::*;
(
	input  logic                  aclk,
	input  logic                  rst,
	input  logic                  lookup_valid,
	input  lookup_req_t           req,
	input  logic                  tlb_we,
	input  logic [`TLB_IDX_W-1:0] wr_index,
	input  tlb_entry_t            wr_entry,
	output logic                  result_valid,
	output tlb_result_t           result
);

	seg_stage_t   stage;
	entry_match_t match_vec [`TLB_ENTRIES];

	// stage 1, segment check and request register
	addr_segment_map u_seg (
		.aclk         (aclk),
		.rst          (rst),
		.lookup_valid (lookup_valid),
		.req          (req),
		.stage        (stage)
	);

	// fully associative compare, one instance per entry
	for (genvar gi = 0; gi < `TLB_ENTRIES; gi++) begin : g_entry
		tlb_entry #(
			.ENTRY_ID (gi)
		) u_entry (
			.aclk     (aclk),
			.rst      (rst),
			.tlb_we   (tlb_we),
			.wr_index (wr_index),
			.wr_entry (wr_entry),
			.stage    (stage),
			.match    (match_vec[gi])
		);
	end

	// stage 2, hit select and fault flags
	tlb_hit_resolve u_resolve (
		.aclk         (aclk),
		.rst          (rst),
		.stage        (stage),
		.match        (match_vec),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

//--- verif/tlb_mmu_tb.sv
`timescale 1ns/1ps
`include "tlb_defines.svh"

module tlb_mmu_tb
	import tlb_pkg::*;
;

	typedef struct {
		bit                    is_write;
		bit                    drain;
		logic [`TLB_IDX_W-1:0] idx;
		tlb_entry_t            ent;
		lookup_req_t           req;
		tlb_result_t           exp;
	} row_t;

	logic                  aclk;
	logic                  rst;
	logic                  lookup_valid;
	lookup_req_t           req;
	logic                  tlb_we;
	logic [`TLB_IDX_W-1:0] wr_index;
	tlb_entry_t            wr_entry;
	logic                  result_valid;
	tlb_result_t           result;

	row_t        rows[$];
	tlb_result_t exp_q[$];
	int          cyc_q[$];
	int          neg_cnt;
	tlb_result_t exp_head;
	int          cyc_head;

	tlb_mmu uut (
		.aclk         (aclk),
		.rst          (rst),
		.lookup_valid (lookup_valid),
		.req          (req),
		.tlb_we       (tlb_we),
		.wr_index     (wr_index),
		.wr_entry     (wr_entry),
		.result_valid (result_valid),
		.result       (result)
	);

	initial begin
		aclk = 1'b0;
		forever #2 aclk = ~aclk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp));
		end
	endtask

	task automatic check_result(input tlb_result_t got, input tlb_result_t exp);
		compare_field("result.pa", got.pa, exp.pa);
		compare_field("result.miss", 32'(got.miss), 32'(exp.miss));
		compare_field("result.invalid", 32'(got.invalid), 32'(exp.invalid));
		compare_field("result.modify", 32'(got.modify), 32'(exp.modify));
		compare_field("result.uncache", 32'(got.uncache), 32'(exp.uncache));
		compare_field("result.mapped", 32'(got.mapped), 32'(exp.mapped));
		compare_field("result.index", 32'(got.index), 32'(exp.index));
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp) begin
			abort_run($sformatf("FAIL time=%0t latency got=%0d expected=%0d", $time, got, exp));
		end
	endtask

	function automatic tlb_entry_t make_entry(input logic [18:0] vpn2, input logic [7:0] asid,
			input logic g, input logic [19:0] pfn0, input logic d0, input logic v0,
			input logic [19:0] pfn1, input logic d1, input logic v1);
		tlb_entry_t e;
		e = '{vpn2: vpn2, asid: asid, g: g, pfn0: pfn0, d0: d0, v0: v0,
			pfn1: pfn1, d1: d1, v1: v1};
		return e;
	endfunction

	function automatic lookup_req_t make_req(input logic [31:0] va, input logic [7:0] asid,
			input access_kind_e kind);
		lookup_req_t r;
		r = '{va: va, asid: asid, kind: kind};
		return r;
	endfunction

	function automatic tlb_result_t make_res(input logic [31:0] pa, input logic miss,
			input logic invalid, input logic modify, input logic uncache, input logic mapped,
			input logic [1:0] index);
		tlb_result_t r;
		r = '{pa: pa, miss: miss, invalid: invalid, modify: modify, uncache: uncache,
			mapped: mapped, index: index};
		return r;
	endfunction

	task automatic add_write(input logic [1:0] idx, input tlb_entry_t ent);
		row_t r;
		r = '{is_write: 1'b1, drain: 1'b0, idx: idx, ent: ent, req: '0, exp: '0};
		rows.push_back(r);
	endtask

	task automatic add_lookup(input lookup_req_t rq, input tlb_result_t exp, input bit drain);
		row_t r;
		r = '{is_write: 1'b0, drain: drain, idx: '0, ent: '0, req: rq, exp: exp};
		rows.push_back(r);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 20) begin
			@(posedge aclk);
			n++;
		end
		if (exp_q.size() != 0) begin
			abort_run("timeout while waiting for result_valid");
		end
	endtask

	task automatic build_table();
		// reset state, entry 0 is all zeros
		add_lookup(make_req(32'h0000_0100, 8'h00, acc_load), make_res(32'h0, 0, 1, 0, 0, 1, 0), 1);
		// kseg0 and kseg1
		add_lookup(make_req(32'h8001_2345, 8'h12, acc_load), make_res(32'h0001_2345, 0, 0, 0, 0, 0, 0), 1);
		add_lookup(make_req(32'ha012_3456, 8'h12, acc_store), make_res(32'h0012_3456, 0, 0, 0, 1, 0, 0), 1);
		// even and odd page of entry 1
		add_write(2'd1, make_entry(19'h00040, 8'h12, 0, 20'h0abcd, 1, 1, 20'h12345, 1, 1));
		add_lookup(make_req(32'h0008_0123, 8'h12, acc_load), make_res(32'h0abc_d123, 0, 0, 0, 0, 1, 1), 1);
		add_lookup(make_req(32'h0008_1ffc, 8'h12, acc_load), make_res(32'h1234_5ffc, 0, 0, 0, 0, 1, 1), 1);
		add_lookup(make_req(32'h0008_0123, 8'h12, acc_store), make_res(32'h0abc_d123, 0, 0, 0, 0, 1, 1), 1);
		// asid mismatch, then global
		add_lookup(make_req(32'h0008_0123, 8'h34, acc_load), make_res(32'h0, 1, 0, 0, 0, 1, 0), 1);
		add_write(2'd1, make_entry(19'h00040, 8'h12, 1, 20'h0abcd, 1, 1, 20'h12345, 1, 1));
		add_lookup(make_req(32'h0008_0123, 8'h34, acc_load), make_res(32'h0abc_d123, 0, 0, 0, 0, 1, 1), 1);
		// clean even page, invalid odd page
		add_write(2'd2, make_entry(19'h00100, 8'h12, 0, 20'h00777, 0, 1, 20'h00888, 1, 0));
		add_lookup(make_req(32'h0020_0010, 8'h12, acc_store), make_res(32'h0077_7010, 0, 0, 1, 0, 1, 2), 1);
		add_lookup(make_req(32'h0020_0010, 8'h12, acc_load), make_res(32'h0077_7010, 0, 0, 0, 0, 1, 2), 1);
		add_lookup(make_req(32'h0020_1010, 8'h12, acc_load), make_res(32'h0, 0, 1, 0, 0, 1, 0), 1);
		// entry 3 shadows entry 2
		add_write(2'd3, make_entry(19'h00100, 8'h12, 0, 20'h00999, 1, 1, 20'h00aaa, 1, 1));
		add_lookup(make_req(32'h0020_0010, 8'h12, acc_load), make_res(32'h0077_7010, 0, 0, 0, 0, 1, 2), 1);
		add_lookup(make_req(32'h0400_0000, 8'h12, acc_load), make_res(32'h0, 1, 0, 0, 0, 1, 0), 1);
		add_lookup(make_req(32'hc000_0000, 8'h12, acc_load), make_res(32'h0, 1, 0, 0, 0, 1, 0), 1);
		// back to back
		add_lookup(make_req(32'ha000_0040, 8'h12, acc_load), make_res(32'h0000_0040, 0, 0, 0, 1, 0, 0), 0);
		add_lookup(make_req(32'h0008_1004, 8'h12, acc_load), make_res(32'h1234_5004, 0, 0, 0, 0, 1, 1), 0);
		add_lookup(make_req(32'h0400_0000, 8'h12, acc_load), make_res(32'h0, 1, 0, 0, 0, 1, 0), 0);
		add_lookup(make_req(32'h0020_0ff0, 8'h12, acc_store), make_res(32'h0077_7ff0, 0, 0, 1, 0, 1, 2), 0);
		add_lookup(make_req(32'h9fff_fffc, 8'h12, acc_load), make_res(32'h1fff_fffc, 0, 0, 0, 0, 0, 0), 1);
	endtask

	// result monitor, sampled mid cycle
	always @(negedge aclk) begin
		if (result_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				abort_run("result_valid pulsed with no lookup outstanding");
			end
			exp_head = exp_q.pop_front();
			cyc_head = cyc_q.pop_front();
			check_latency(neg_cnt - cyc_head, 2);
			check_result(result, exp_head);
		end
		neg_cnt = neg_cnt + 1;
	end

	initial begin
		neg_cnt      = 0;
		rst          = 1'b0;
		lookup_valid = 1'b0;
		req          = '0;
		tlb_we       = 1'b0;
		wr_index     = '0;
		wr_entry     = '0;
		build_table();
		repeat (4) @(posedge aclk);
		rst <= 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			@(posedge aclk);
			tlb_we       <= 1'b0;
			lookup_valid <= 1'b0;
			if (rows[i].is_write) begin
				tlb_we   <= 1'b1;
				wr_index <= rows[i].idx;
				wr_entry <= rows[i].ent;
			end else begin
				lookup_valid <= 1'b1;
				req          <= rows[i].req;
				exp_q.push_back(rows[i].exp);
				cyc_q.push_back(neg_cnt);
			end
			if (rows[i].drain) begin
				@(posedge aclk);
				tlb_we       <= 1'b0;
				lookup_valid <= 1'b0;
				wait_drain();
			end
		end
		@(posedge aclk);
		tlb_we       <= 1'b0;
		lookup_valid <= 1'b0;
		wait_drain();
		if (exp_q.size() == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			abort_run("expected results left over at end of test");
		end
	end

endmodule

//--- files.f
+incdir+hw
hw/tlb_pkg.sv
hw/addr_segment_map.sv
hw/tlb_entry.sv
hw/tlb_hit_resolve.sv
hw/tlb_mmu.sv
verif/tlb_mmu_tb.sv

//--- Makefile
TOP = tlb_mmu_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with verilator, run it, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	rm -f sim.log
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
